// File: common/comms_params.svh
`ifndef COMMS_PARAMS_SVH
`define COMMS_PARAMS_SVH

`define COMMS_PACKET_WIDTH 32
`define COMMS_GLOBAL_ID 255     // broadcast chip id
`define COMMS_READ_LATENCY 5    // cycles spent in the register-read state
`define COMMS_TIMEOUT 15        // max cycles in the wait state
`define COMMS_FIFO_DEPTH 8
`define COMMS_REGMAP_DEPTH 16

// packet field positions
`define COMMS_KIND_MSB 1
`define COMMS_KIND_LSB 0
`define COMMS_ID_MSB 9
`define COMMS_ID_LSB 2
`define COMMS_ADDR_MSB 17
`define COMMS_ADDR_LSB 10
`define COMMS_DATA_MSB 25
`define COMMS_DATA_LSB 18
`define COMMS_REPLY_BIT 31      // set on a read reply

`endif

// File: common/comms_pkg.sv
`include "comms_params.svh"

package comms_pkg;

    ////////////////////////////////////////////////////////////
    // packet as carried between the UARTs and the FIFO
    ////////////////////////////////////////////////////////////

    typedef logic [`COMMS_PACKET_WIDTH-1:0] packet_t;

    // kind field, bits 1..0 of every packet
    typedef enum logic [1:0] {
        DATA         = 2'd0,
        TEST         = 2'd1,
        CONFIG_WRITE = 2'd2,
        CONFIG_READ  = 2'd3
    } packet_kind_e;

endpackage

// File: common/regmap_pkg.sv
package regmap_pkg;

    ////////////////////////////////////////////////////////////
    // configuration register map
    ////////////////////////////////////////////////////////////

    typedef logic [7:0] reg_addr_t;   // full address field, upper part unused
    typedef logic [7:0] reg_data_t;

endpackage

// File: comms/comms_timer.sv
`timescale 1ns/1ps
`include "comms_params.svh"

module comms_timer (
    input  logic clk,
    input  logic reset_n,
    input  logic timer_run,   // count while high, clear while low
    output logic read_done,
    output logic timed_out
);

    logic [3:0] count;        // running cycles already completed
    logic [3:0] cycle_no;     // number of the current running cycle

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            count <= '0;
        else if (!timer_run)
            count <= '0;
        else if (cycle_no != 4'(`COMMS_TIMEOUT))
            count <= count + 4'd1;               // holds once the timeout is reached
    end

    assign cycle_no = count + 4'd1;

    // thresholds only count while running
    assign read_done = timer_run && (cycle_no == 4'(`COMMS_READ_LATENCY));
    assign timed_out = timer_run && (cycle_no == 4'(`COMMS_TIMEOUT));

endmodule

// File: comms/comms_ctrl.sv
`timescale 1ns/1ps
`include "comms_params.svh"

module comms_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  comms_pkg::packet_t    rx_data,            // word from rx UART
    input  logic                  rx_data_flag,       // one-cycle pulse per rx word
    input  comms_pkg::packet_t    pre_event,          // event from the router
    input  logic                  load_event,
    input  logic [7:0]            chip_id,
    input  regmap_pkg::reg_data_t regmap_read_data,
    input  logic                  read_done,          // read latency elapsed
    input  logic                  timed_out,          // wait state too long
    output comms_pkg::packet_t    output_event,       // word to the FIFO
    output logic                  write_fifo_n,
    output regmap_pkg::reg_addr_t regmap_address,
    output regmap_pkg::reg_data_t regmap_write_data,
    output logic                  write_regmap,
    output logic                  read_regmap,
    output logic                  timer_run,
    output logic                  comms_busy
);

    typedef enum logic [2:0] {
        S_READY          = 3'h0,
        S_CONFIG_WRITE   = 3'h1,
        S_CONFIG_READ    = 3'h2,
        S_READ_LATCH     = 3'h3,
        S_PASS_ALONG     = 3'h4,
        S_WAIT_FOR_WRITE = 3'h5,
        S_WRITE_FIFO     = 3'h6,
        S_WAIT           = 3'h7
    } state_e;

    state_e                  state;
    state_e                  next_state;
    logic                    global_read_flag;  // forward the original after the reply
    comms_pkg::packet_kind_e rx_kind;
    logic [7:0]              rx_id;
    logic                    is_global;
    logic                    addressed;         // this chip or broadcast
    comms_pkg::packet_t      reply;

    ////////////////////////////////////////////////////////////
    // packet decode
    ////////////////////////////////////////////////////////////

    assign rx_kind   = comms_pkg::packet_kind_e'(rx_data[`COMMS_KIND_MSB:`COMMS_KIND_LSB]);
    assign rx_id     = rx_data[`COMMS_ID_MSB:`COMMS_ID_LSB];
    assign is_global = (rx_id == 8'(`COMMS_GLOBAL_ID));
    assign addressed = is_global || (rx_id == chip_id);

    // reply carries register value and our own id
    always_comb begin
        reply = rx_data;
        reply[`COMMS_DATA_MSB:`COMMS_DATA_LSB] = regmap_read_data;
        reply[`COMMS_ID_MSB:`COMMS_ID_LSB] = chip_id;
    end

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= S_READY;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = S_READY;
        case (state)
            S_READY: begin
                if (rx_data_flag && addressed && rx_kind == comms_pkg::CONFIG_WRITE)
                    next_state = S_CONFIG_WRITE;
                else if (rx_data_flag && addressed && rx_kind == comms_pkg::CONFIG_READ)
                    next_state = S_CONFIG_READ;
                else if (rx_data_flag)
                    next_state = S_PASS_ALONG;
                else if (load_event)
                    next_state = S_WAIT_FOR_WRITE;
            end
            S_CONFIG_WRITE:   next_state = is_global ? S_PASS_ALONG : S_WAIT;
            S_CONFIG_READ:    next_state = read_done ? S_READ_LATCH : S_CONFIG_READ;
            S_READ_LATCH:     next_state = S_WRITE_FIFO;
            S_PASS_ALONG:     next_state = S_WRITE_FIFO;
            S_WAIT_FOR_WRITE: next_state = S_WRITE_FIFO;
            S_WRITE_FIFO:     next_state = (is_global && global_read_flag) ? S_PASS_ALONG : S_WAIT;
            S_WAIT:           next_state = (!rx_data_flag || timed_out) ? S_READY : S_WAIT;
            default:          next_state = S_READY;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // outputs, registered from the next state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            output_event      <= '0;
            write_fifo_n      <= 1'b1;
            regmap_address    <= '0;
            regmap_write_data <= '0;
            write_regmap      <= 1'b0;
            read_regmap       <= 1'b0;
            timer_run         <= 1'b0;
            comms_busy        <= 1'b0;
            global_read_flag  <= 1'b0;
        end else begin
            write_fifo_n      <= 1'b1;             // strobes default inactive
            regmap_address    <= '0;
            regmap_write_data <= '0;
            write_regmap      <= 1'b0;
            read_regmap       <= 1'b0;
            timer_run         <= (next_state == S_CONFIG_READ) || (next_state == S_WAIT);
            comms_busy        <= (next_state != S_READY);
            case (next_state)
                S_CONFIG_WRITE: begin
                    regmap_address    <= rx_data[`COMMS_ADDR_MSB:`COMMS_ADDR_LSB];
                    regmap_write_data <= rx_data[`COMMS_DATA_MSB:`COMMS_DATA_LSB];
                    write_regmap      <= 1'b1;
                end
                S_CONFIG_READ: begin
                    regmap_address <= rx_data[`COMMS_ADDR_MSB:`COMMS_ADDR_LSB];
                    read_regmap    <= 1'b1;
                    output_event   <= reply;           // settles before the latch
                    if (is_global)
                        global_read_flag <= 1'b1;
                end
                S_READ_LATCH:     output_event[`COMMS_REPLY_BIT] <= 1'b1; // mark as reply
                S_PASS_ALONG: begin
                    output_event     <= rx_data;       // unchanged copy
                    global_read_flag <= 1'b0;
                end
                S_WAIT_FOR_WRITE: output_event <= pre_event;
                S_WRITE_FIFO:     write_fifo_n <= 1'b0;
                default: ;
            endcase
        end
    end

endmodule

// File: design/config_regmap.sv
`timescale 1ns/1ps
`include "comms_params.svh"

module config_regmap (
    input  logic                  clk,
    input  logic                  reset_n,
    input  regmap_pkg::reg_addr_t regmap_address,
    input  regmap_pkg::reg_data_t regmap_write_data,
    input  logic                  write_regmap,
    input  logic                  read_regmap,
    output regmap_pkg::reg_data_t regmap_read_data
);

    localparam int IDX_W = $clog2(`COMMS_REGMAP_DEPTH);

    regmap_pkg::reg_data_t regs [`COMMS_REGMAP_DEPTH];
    logic                  in_range;     // address inside the map
    logic [IDX_W-1:0]      idx;

    assign in_range = (regmap_address < 8'(`COMMS_REGMAP_DEPTH));
    assign idx      = regmap_address[IDX_W-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `COMMS_REGMAP_DEPTH; i++)
                regs[i] <= '0;
        end else if (write_regmap && in_range) begin
            regs[idx] <= regmap_write_data;  // out-of-range writes dropped
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            regmap_read_data <= '0;
        else if (read_regmap)
            regmap_read_data <= in_range ? regs[idx] : '0;
    end

endmodule

// File: design/event_fifo.sv
`timescale 1ns/1ps
`include "comms_params.svh"

module event_fifo (
    input  logic               clk,
    input  logic               reset_n,
    input  comms_pkg::packet_t output_event,  // word from comms_ctrl
    input  logic               write_fifo_n,  // active low
    input  logic               read_fifo_n,   // active low
    output comms_pkg::packet_t fifo_data,     // head word, valid cycle after read
    output logic               fifo_empty,
    output logic               fifo_full
);

    localparam int PTR_W = $clog2(`COMMS_FIFO_DEPTH);

    comms_pkg::packet_t mem [`COMMS_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               wr_en;
    logic               rd_en;

    assign wr_en      = !write_fifo_n && !fifo_full;
    assign rd_en      = !read_fifo_n && !fifo_empty;
    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == (PTR_W + 1)'(`COMMS_FIFO_DEPTH));

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;         // wraps at depth
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and read register
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= output_event;
        if (rd_en)
            fifo_data <= mem[rd_ptr];
    end

endmodule

// File: design/fifo_rd_ctrl.sv
`timescale 1ns/1ps

module fifo_rd_ctrl (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               fifo_empty,
    input  logic               tx_busy,      // tx UART sending
    input  comms_pkg::packet_t fifo_data,
    output logic               read_fifo_n,  // active low
    output logic               ld_tx_data,   // one-cycle load strobe
    output comms_pkg::packet_t tx_data
);

    typedef enum logic [1:0] {
        R_IDLE = 2'd0,
        R_READ = 2'd1,
        R_HOLD = 2'd2   // load issued, wait for the UART to go busy
    } rd_state_e;

    rd_state_e state;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= R_IDLE;
            read_fifo_n <= 1'b1;
            ld_tx_data  <= 1'b0;
        end else begin
            read_fifo_n <= 1'b1;
            ld_tx_data  <= 1'b0;
            case (state)
                R_IDLE: if (!fifo_empty && !tx_busy) begin
                    read_fifo_n <= 1'b0;
                    state       <= R_READ;
                end
                R_READ: begin
                    ld_tx_data <= 1'b1;       // fifo_data valid next cycle
                    state      <= R_HOLD;
                end
                R_HOLD: if (tx_busy)
                    state <= R_IDLE;          // busy seen, idle waits for it to drop
                default: state <= R_IDLE;
            endcase
        end
    end

    assign tx_data = fifo_data;

endmodule

// File: design/chip_comms_top.sv
`timescale 1ns/1ps

module chip_comms_top (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [7:0]         chip_id,
    input  comms_pkg::packet_t rx_data,
    input  logic               rx_data_flag,
    input  comms_pkg::packet_t pre_event,
    input  logic               load_event,
    input  logic               tx_busy,
    output comms_pkg::packet_t tx_data,
    output logic               ld_tx_data,
    output logic               comms_busy
);

    comms_pkg::packet_t    output_event;
    comms_pkg::packet_t    fifo_data;
    logic                  write_fifo_n;
    logic                  read_fifo_n;
    logic                  fifo_empty;
    logic                  fifo_full;      // watched by the checker
    regmap_pkg::reg_addr_t regmap_address;
    regmap_pkg::reg_data_t regmap_write_data;
    regmap_pkg::reg_data_t regmap_read_data;
    logic                  write_regmap;
    logic                  read_regmap;
    logic                  timer_run;
    logic                  read_done;
    logic                  timed_out;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    comms_ctrl u_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .rx_data           (rx_data),
        .rx_data_flag      (rx_data_flag),
        .pre_event         (pre_event),
        .load_event        (load_event),
        .chip_id           (chip_id),
        .regmap_read_data  (regmap_read_data),
        .read_done         (read_done),
        .timed_out         (timed_out),
        .output_event      (output_event),
        .write_fifo_n      (write_fifo_n),
        .regmap_address    (regmap_address),
        .regmap_write_data (regmap_write_data),
        .write_regmap      (write_regmap),
        .read_regmap       (read_regmap),
        .timer_run         (timer_run),
        .comms_busy        (comms_busy)
    );

    comms_timer u_timer (
        .clk       (clk),
        .reset_n   (reset_n),
        .timer_run (timer_run),
        .read_done (read_done),
        .timed_out (timed_out)
    );

    ////////////////////////////////////////////////////////////
    // data path
    ////////////////////////////////////////////////////////////

    config_regmap u_regmap (
        .clk               (clk),
        .reset_n           (reset_n),
        .regmap_address    (regmap_address),
        .regmap_write_data (regmap_write_data),
        .write_regmap      (write_regmap),
        .read_regmap       (read_regmap),
        .regmap_read_data  (regmap_read_data)
    );

    event_fifo u_fifo (
        .clk          (clk),
        .reset_n      (reset_n),
        .output_event (output_event),
        .write_fifo_n (write_fifo_n),
        .read_fifo_n  (read_fifo_n),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .fifo_full    (fifo_full)
    );

    fifo_rd_ctrl u_rd_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .fifo_empty  (fifo_empty),
        .tx_busy     (tx_busy),
        .fifo_data   (fifo_data),
        .read_fifo_n (read_fifo_n),
        .ld_tx_data  (ld_tx_data),
        .tx_data     (tx_data)
    );

endmodule

// File: test/chip_comms_chk.sv
`timescale 1ns/1ps

module chip_comms_chk (
    input logic clk,
    input logic reset_n,
    input logic read_fifo_n,
    input logic write_fifo_n,
    input logic fifo_empty,
    input logic fifo_full,
    input logic ld_tx_data,
    input logic write_regmap,
    input logic read_regmap
);

    int assert_errors = 0;   // failures seen so far

    a_read_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
        !(!read_fifo_n && fifo_empty))
        else begin
            $error("FIFO read strobe while the FIFO is empty");
            assert_errors++;
        end

    a_write_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        !(!write_fifo_n && fifo_full))
        else begin
            $error("FIFO write strobe while the FIFO is full");
            assert_errors++;
        end

    // load strobe comes exactly one cycle after the read strobe
    a_load_after_read: assert property (@(posedge clk) disable iff (!reset_n)
        !read_fifo_n |=> ld_tx_data)
        else begin
            $error("ld_tx_data missing one cycle after read_fifo_n");
            assert_errors++;
        end

    a_load_needs_read: assert property (@(posedge clk) disable iff (!reset_n)
        ld_tx_data |-> ($past(read_fifo_n) == 1'b0))
        else begin
            $error("ld_tx_data without a read_fifo_n one cycle before");
            assert_errors++;
        end

    a_regmap_strobes: assert property (@(posedge clk) disable iff (!reset_n)
        !(write_regmap && read_regmap))
        else begin
            $error("write_regmap and read_regmap high together");
            assert_errors++;
        end

endmodule

bind chip_comms_top chip_comms_chk u_chk (
    .clk          (clk),
    .reset_n      (reset_n),
    .read_fifo_n  (read_fifo_n),
    .write_fifo_n (write_fifo_n),
    .fifo_empty   (fifo_empty),
    .fifo_full    (fifo_full),
    .ld_tx_data   (ld_tx_data),
    .write_regmap (write_regmap),
    .read_regmap  (read_regmap)
);

// File: test/tb_chip_comms.sv
`timescale 1ns/1ps
`include "comms_params.svh"

module tb_chip_comms;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS     = 20;
    localparam int ROW_CYCLES   = 200;    // watchdog budget per row
    localparam int WORD_WAIT    = 100;    // max idle cycles while waiting for a word
    localparam int READY_WAIT   = 60;
    localparam logic [7:0] OWN_ID = 8'h2a;

    typedef struct packed {
        logic               from_load;   // pre_event instead of rx
        logic               check_now;   // collect the queued words after this row
        logic [1:0]         n_exp;
        comms_pkg::packet_t pkt;
        comms_pkg::packet_t exp0;
        comms_pkg::packet_t exp1;
    } row_t;

    logic                  clk;
    logic                  reset_n;
    logic [7:0]            chip_id;
    comms_pkg::packet_t    rx_data;
    logic                  rx_data_flag;
    comms_pkg::packet_t    pre_event;
    logic                  load_event;
    logic                  tx_busy;
    comms_pkg::packet_t    tx_data;
    logic                  ld_tx_data;
    logic                  comms_busy;

    row_t                  rows [NUM_ROWS];
    string                 row_name [NUM_ROWS];
    int                    n_rows;
    regmap_pkg::reg_data_t ref_regs [`COMMS_REGMAP_DEPTH];  // reference register map
    comms_pkg::packet_t    tx_queue [$];    // words seen on ld_tx_data
    comms_pkg::packet_t    exp_queue [$];
    int                    error_count;
    int                    check_count;
    int                    rows_failed;
    int unsigned           busy_len;

    chip_comms_top u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .chip_id      (chip_id),
        .rx_data      (rx_data),
        .rx_data_flag (rx_data_flag),
        .pre_event    (pre_event),
        .load_event   (load_event),
        .tx_busy      (tx_busy),
        .tx_data      (tx_data),
        .ld_tx_data   (ld_tx_data),
        .comms_busy   (comms_busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // transmit UART model and output monitor
    ////////////////////////////////////////////////////////////

    always begin
        @(negedge clk);
        if (reset_n && ld_tx_data) begin
            busy_len = 2 + ($urandom % 8);          // 2 to 9 cycles
            @(posedge clk);
            #1 tx_busy = 1'b1;
            repeat (busy_len) @(posedge clk);
            #1 tx_busy = 1'b0;
        end
    end

    // a load while the UART is sending would be lost by a real UART
    always @(negedge clk) begin
        if (reset_n && ld_tx_data) begin
            if (tx_busy) begin
                $display("packet %h loaded while the transmit UART was busy", tx_data);
                error_count++;
            end
            tx_queue.push_back(tx_data);
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    function automatic comms_pkg::packet_t mk_pkt(input logic [1:0] kind, input logic [7:0] id,
                                                  input logic [7:0] addr, input logic [7:0] data,
                                                  input logic [4:0] tag);
        comms_pkg::packet_t p;
        p = '0;
        p[`COMMS_KIND_MSB:`COMMS_KIND_LSB] = kind;
        p[`COMMS_ID_MSB:`COMMS_ID_LSB]     = id;
        p[`COMMS_ADDR_MSB:`COMMS_ADDR_LSB] = addr;
        p[`COMMS_DATA_MSB:`COMMS_DATA_LSB] = data;
        p[30:26]                           = tag;   // spare bits must pass untouched
        return p;
    endfunction

    // expected words follow the packet rules and the reference register map
    task automatic add_row(input logic from_load, input logic check_now,
                           input comms_pkg::packet_t pkt, input string name);
        row_t       r;
        logic [1:0] kind;
        logic [7:0] id;
        logic [7:0] addr;
        logic       bcast;
        logic       addressed;
        kind      = pkt[`COMMS_KIND_MSB:`COMMS_KIND_LSB];
        id        = pkt[`COMMS_ID_MSB:`COMMS_ID_LSB];
        addr      = pkt[`COMMS_ADDR_MSB:`COMMS_ADDR_LSB];
        bcast     = (id == 8'(`COMMS_GLOBAL_ID));
        addressed = bcast || (id == OWN_ID);
        r           = '0;
        r.from_load = from_load;
        r.check_now = check_now;
        r.pkt       = pkt;
        r.exp0      = pkt;
        r.exp1      = pkt;
        r.n_exp     = 2'd1;
        if (!from_load && addressed && kind == comms_pkg::CONFIG_WRITE) begin
            if (addr < `COMMS_REGMAP_DEPTH)
                ref_regs[addr] = pkt[`COMMS_DATA_MSB:`COMMS_DATA_LSB];
            r.n_exp = bcast ? 2'd1 : 2'd0;                 // broadcast is forwarded
        end else if (!from_load && addressed && kind == comms_pkg::CONFIG_READ) begin
            r.exp0[`COMMS_DATA_MSB:`COMMS_DATA_LSB] =
                (addr < `COMMS_REGMAP_DEPTH) ? ref_regs[addr] : 8'h00;
            r.exp0[`COMMS_ID_MSB:`COMMS_ID_LSB] = OWN_ID;
            r.exp0[`COMMS_REPLY_BIT]            = 1'b1;
            r.n_exp = bcast ? 2'd2 : 2'd1;                 // reply, then the original
        end
        rows[n_rows]     = r;
        row_name[n_rows] = name;
        n_rows++;
    endtask

    task automatic build_table;
        for (int i = 0; i < `COMMS_REGMAP_DEPTH; i++)
            ref_regs[i] = 8'h00;
        n_rows = 0;
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_WRITE, OWN_ID, 8'h03, 8'h5c, 5'h01), "own write");
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_READ, OWN_ID, 8'h03, 8'hff, 5'h02), "own read");
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_WRITE, 8'hff, 8'h07, 8'ha6, 5'h03), "bcast write");
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_READ, OWN_ID, 8'h07, 8'h00, 5'h04), "read bcast");
        add_row(0, 1, mk_pkt(comms_pkg::DATA, OWN_ID, 8'h03, 8'h11, 5'h05), "data");
        add_row(0, 1, mk_pkt(comms_pkg::TEST, 8'h13, 8'h09, 8'h22, 5'h06), "test");
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_WRITE, 8'h13, 8'h03, 8'hee, 5'h07), "foreign wr");
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_READ, 8'h13, 8'h03, 8'h33, 5'h08), "foreign rd");
        // 8'h13 shares its low bits with register 3
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_WRITE, OWN_ID, 8'h13, 8'h77, 5'h0b), "high write");
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_READ, OWN_ID, 8'h13, 8'h66, 5'h0c), "high read");
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_READ, OWN_ID, 8'h03, 8'h44, 5'h09), "reread");
        add_row(1, 1, 32'h1234_5678, "load event");
        add_row(0, 1, mk_pkt(comms_pkg::CONFIG_READ, 8'hff, 8'h07, 8'h55, 5'h0a), "bcast read");
        for (int i = 0; i < 7; i++)                         // burst behind a busy UART
            add_row(i == 3, i == 6,
                    mk_pkt((i % 2) ? comms_pkg::TEST : comms_pkg::DATA, 8'h40 + 8'(i),
                           8'h80 + 8'(i), 8'h10 * 8'(i), 5'h10 + 5'(i)),
                    $sformatf("burst %0d", i));
    endtask

    ////////////////////////////////////////////////////////////
    // checks and row handling
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input comms_pkg::packet_t expected,
                               input comms_pkg::packet_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("Mismatch %s expected %h got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_ready(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (comms_busy && cycles < READY_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (comms_busy) begin
            $display("comms_busy stuck high before row %0d", idx);
            error_count++;
        end
    endtask

    task automatic collect_words(input int idx);
        int                 idle;
        int                 seen;
        comms_pkg::packet_t exp_word;
        comms_pkg::packet_t got_word;
        idle = 0;
        seen = tx_queue.size();
        while (tx_queue.size() < exp_queue.size() && idle < WORD_WAIT) begin
            @(posedge clk);
            if (tx_queue.size() != seen) begin
                seen = tx_queue.size();
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (tx_queue.size() < exp_queue.size()) begin
            $display("no packet transmitted for row %0d", idx);
            error_count++;
            exp_queue.delete();
            tx_queue.delete();
        end else begin
            while (exp_queue.size() > 0) begin
                exp_word = exp_queue.pop_front();
                got_word = tx_queue.pop_front();
                check_value("tx_data", exp_word, got_word);
            end
        end
    endtask

    task automatic run_row(input int idx);
        int errs_before;
        errs_before = error_count;
        wait_ready(idx);
        @(posedge clk);
        #1;
        if (rows[idx].from_load) begin
            pre_event  = rows[idx].pkt;
            load_event = 1'b1;
        end else begin
            rx_data      = rows[idx].pkt;    // held until the next rx word
            rx_data_flag = 1'b1;
        end
        @(posedge clk);
        #1;
        load_event   = 1'b0;
        rx_data_flag = 1'b0;
        if (rows[idx].n_exp > 0)
            exp_queue.push_back(rows[idx].exp0);
        if (rows[idx].n_exp > 1)
            exp_queue.push_back(rows[idx].exp1);
        if (!rows[idx].check_now) begin
            $display("row %0d %s: queued", idx, row_name[idx]);
        end else begin
            collect_words(idx);
            if (error_count == errs_before) begin
                $display("row %0d %s: ok", idx, row_name[idx]);
            end else begin
                $display("row %0d %s: %0d errors", idx, row_name[idx], error_count - errs_before);
                rows_failed++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'ha8cb_e59c));
        clk          = 1'b0;
        reset_n      = 1'b0;
        chip_id      = OWN_ID;
        rx_data      = '0;
        rx_data_flag = 1'b0;
        pre_event    = '0;
        load_event   = 1'b0;
        tx_busy      = 1'b0;
        error_count  = 0;
        check_count  = 0;
        rows_failed  = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_n = 1'b1;
        for (int i = 0; i < n_rows; i++)
            run_row(i);
        repeat (50) @(posedge clk);
        while (tx_queue.size() > 0) begin
            $display("unexpected packet %h transmitted after the last row", tx_queue[0]);
            void'(tx_queue.pop_front());
            error_count++;
        end
        if (u_dut.u_chk.assert_errors != 0) begin
            $display("%0d strobe assertion failures", u_dut.u_chk.assert_errors);
            error_count = error_count + u_dut.u_chk.assert_errors;
        end
        $display("rows %0d, failed %0d, checks %0d, errors %0d",
                 n_rows, rows_failed, check_count, error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_ROWS * ROW_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped",
                 RESET_CYCLES + NUM_ROWS * ROW_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: chip_comms.f
+incdir+common
common/comms_pkg.sv
common/regmap_pkg.sv
comms/comms_timer.sv
comms/comms_ctrl.sv
design/config_regmap.sv
design/event_fifo.sv
design/fifo_rd_ctrl.sv
design/chip_comms_top.sv
test/chip_comms_chk.sv
test/tb_chip_comms.sv

// File: Bender.yml
package:
  name: chip_comms

sources:
  - include_dirs:
      - common
    files:
      - common/comms_pkg.sv
      - common/regmap_pkg.sv
      - comms/comms_timer.sv
      - comms/comms_ctrl.sv
      - design/config_regmap.sv
      - design/event_fifo.sv
      - design/fifo_rd_ctrl.sv
      - design/chip_comms_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/chip_comms_chk.sv
      - test/tb_chip_comms.sv
